/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -sv -f build.f --top-module id_stage_tb -o id_stage_tb
	./obj_dir/id_stage_tb | tee sim.log
	@if grep -q '\*\*\* FAILED \*\*\*' sim.log; then exit 1; fi
	@grep -q '\*\*\* PASSED \*\*\*' sim.log

clean:
	rm -rf obj_dir sim.log

/* build.f */
+incdir+include
hdl/id_pkg.sv
hdl/inst_decoder.sv
hdl/regfile.sv
hdl/operand_bypass.sv
hdl/branch_unit.sv
hdl/id_stage.sv
dv/id_stage_tb.sv

/* include/id_ref_model.svh */
`ifndef ID_REF_MODEL_SVH
`define ID_REF_MODEL_SVH

word_t       shadow [32];   // mirrors every write driven on wb_bus
logic [31:0] lcg_state = 32'h9e4961d0;

function automatic word_t lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
endfunction

// youngest producer first, r0 always zero
function automatic word_t ref_operand(input reg_idx_t idx, input logic need);
    if (idx == 5'd0) return 32'd0;
    if (!need) return shadow[idx];  // raw regfile value
    if (ex_fwd.valid && ex_fwd.dest == idx) return ex_fwd.wdata;
    if (mem_fwd.valid && mem_fwd.dest == idx) return mem_fwd.wdata;
    if (wb_bus.we && wb_bus.waddr == idx) return wb_bus.wdata;
    return shadow[idx];
endfunction

function automatic void id_ref_decode(input word_t inst, input word_t pc,
                                      output id_ex_t e, output br_t b);
    logic [5:0] op;
    logic [3:0] op2;
    logic [4:0] fn;
    logic       ok, nj, nd, rdsrc, pcs, isel, jmp, jirl, bc, cond;
    int         k;
    word_t      imm, offs, a, d, s12;
    op = inst[31:26];
    op2 = inst[25:22];
    fn = inst[19:15];
    s12 = {{20{inst[21]}}, inst[21:10]};
    {ok, nj, nd, rdsrc, pcs, isel, jmp, jirl, bc} = '0;
    k = -1;
    imm = 32'd0;
    offs = {{14{inst[25]}}, inst[25:10], 2'b00};
    e = '0;
    e.pc = pc;
    e.dest = inst[4:0];
    e.gr_we = 1'b1;
    e.mem_size = MEM_W;
    case (op)
        OP_ALU: begin
            ok = 1'b1;
            nj = 1'b1;
            if (op2 == 4'h0 && inst[21:20] == 2'h1) begin
                nd = 1'b1;
                case (fn)
                    FN_ADD: k = ALU_ADD;   FN_SUB: k = ALU_SUB;
                    FN_SLT: k = ALU_SLT;   FN_SLTU: k = ALU_SLTU;
                    FN_NOR: k = ALU_NOR;   FN_AND: k = ALU_AND;
                    FN_OR:  k = ALU_OR;    FN_XOR: k = ALU_XOR;
                    FN_SLL: k = ALU_SLL;   FN_SRL: k = ALU_SRL;
                    FN_SRA: k = ALU_SRA;   default: ok = 1'b0;
                endcase
            end else if (op2 == 4'h1 && inst[21:20] == 2'h0) begin
                isel = 1'b1;
                imm = {27'd0, inst[14:10]};
                case (fn)
                    FN_SLLI: k = ALU_SLL;  FN_SRLI: k = ALU_SRL;
                    FN_SRAI: k = ALU_SRA;  default: ok = 1'b0;
                endcase
            end else begin
                isel = 1'b1;
                imm = s12;
                case (op2)
                    OP2_SLTI: k = ALU_SLT;  OP2_SLTUI: k = ALU_SLTU;
                    OP2_ADDI: k = ALU_ADD;
                    OP2_ANDI: begin k = ALU_AND; imm = {20'd0, inst[21:10]}; end
                    OP2_ORI:  begin k = ALU_OR;  imm = {20'd0, inst[21:10]}; end
                    OP2_XORI: begin k = ALU_XOR; imm = {20'd0, inst[21:10]}; end
                    default: ok = 1'b0;
                endcase
            end
        end
        OP_LDST: begin
            {ok, nj, isel} = 3'b111;
            imm = s12;
            k = ALU_ADD;
            case (op2)
                LS_LD_B:  begin e.is_load = 1'b1; e.mem_size = MEM_B;  end
                LS_LD_H:  begin e.is_load = 1'b1; e.mem_size = MEM_H;  end
                LS_LD_W:  begin e.is_load = 1'b1; e.mem_size = MEM_W;  end
                LS_LD_BU: begin e.is_load = 1'b1; e.mem_size = MEM_BU; end
                LS_LD_HU: begin e.is_load = 1'b1; e.mem_size = MEM_HU; end
                LS_ST_B, LS_ST_H, LS_ST_W: begin
                    {e.is_store, nd, rdsrc} = 3'b111;
                    e.gr_we = 1'b0;
                    e.mem_size = (op2 == LS_ST_B) ? MEM_B : (op2 == LS_ST_H) ? MEM_H : MEM_W;
                end
                default: ok = 1'b0;
            endcase
        end
        OP_LU12I, OP_PCADDU12I: begin
            ok = !inst[25];
            isel = ok;
            imm = ok ? {inst[24:5], 12'd0} : 32'd0;
            pcs = ok && op == OP_PCADDU12I;
            k = (op == OP_LU12I) ? ALU_LUI : ALU_ADD;
        end
        OP_JIRL: begin
            {ok, jirl, nj, pcs, isel} = 5'b11111;
            imm = 32'd4;
            k = ALU_ADD;
        end
        OP_B, OP_BL: begin
            {ok, jmp} = 2'b11;
            offs = {{4{inst[9]}}, inst[9:0], inst[25:10], 2'b00};
            if (op == OP_BL) begin
                e.dest = RA_LINK;
                {pcs, isel} = 2'b11;
                imm = 32'd4;
                k = ALU_ADD;
            end else begin
                e.gr_we = 1'b0;
            end
        end
        OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU: begin
            {ok, bc, nj, nd, rdsrc} = 5'b11111;
            e.gr_we = 1'b0;
        end
        default: ok = 1'b0;
    endcase
    if (!ok) begin
        {nj, nd} = 2'b00;
        k = -1;
        e.gr_we = 1'b0;
    end
    e.ine = !ok;
    if (k >= 0) e.alu_op[k] = 1'b1;
    a = ref_operand(inst[9:5], nj);
    d = ref_operand(rdsrc ? inst[4:0] : inst[14:10], nd);
    e.alu_src1 = pcs ? pc : a;
    e.alu_src2 = isel ? imm : d;
    e.rkd_value = d;
    case (op)
        OP_BEQ:  cond = a == d;
        OP_BNE:  cond = a != d;
        OP_BLT:  cond = $signed(a) < $signed(d);
        OP_BGE:  cond = $signed(a) >= $signed(d);
        OP_BLTU: cond = a < d;
        default: cond = a >= d;
    endcase
    b.taken = jmp || jirl || (bc && cond);
    b.target = (jirl ? a : pc) + offs;
endfunction

`endif

/* dv/id_stage_tb.sv */
module id_stage_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import id_pkg::*;

    localparam int LIMIT = 50;

    logic clk = 1'b0;
    logic resetn = 1'b0;
    logic if_id_valid = 1'b0;
    if_id_t if_id_bus = '0;
    logic id_allowin;
    logic ex_allowin = 1'b1;
    logic id_ex_valid;
    id_ex_t id_ex_bus;
    fwd_t ex_fwd = '0;
    fwd_t mem_fwd = '0;
    wb_t wb_bus = '0;
    logic flush = 1'b0;
    br_t id_br;

    int errors = 0;
    int timeouts = 0;
    word_t pc_next = 32'h1c00_0000;
    if_id_t pending [$];  // instructions expected at execute, in order

    `include "id_ref_model.svh"

    id_stage dut (.*);

    initial begin
        forever #4 clk = ~clk;
    end

    // compare at negedge, every input is settled by then
    always @(negedge clk) begin
        id_ex_t e;
        br_t b;
        if_id_t cur;
        if (resetn && id_ex_valid && ex_allowin) begin
            assert (pending.size() != 0) else begin
                errors++;
                $display("CHECK FAILED at %0t: transfer with no instruction expected", $time);
            end
            if (pending.size() != 0) begin
                cur = pending.pop_front();
                id_ref_decode(cur.inst, cur.pc, e, b);
                assert (id_ex_bus === e) else begin
                    errors++;
                    $display("CHECK FAILED at %0t: inst %h bus %h expected %h",
                             $time, cur.inst, id_ex_bus, e);
                end
                assert (id_br.taken === b.taken && (!b.taken || id_br.target === b.target))
                else begin
                    errors++;
                    $display("CHECK FAILED at %0t: inst %h branch %h expected %h",
                             $time, cur.inst, id_br, b);
                end
            end
        end
    end

    task automatic set_wb(input logic we, input reg_idx_t addr, input word_t data);
        wb_bus = '{we: we, waddr: addr, wdata: data};
        if (we && addr != 5'd0) shadow[addr] = data;
    endtask

    // offer one instruction to the stage, called 1 ns after an edge
    task automatic offer(input word_t inst, input logic expect_leave);
        int n;
        n = 0;
        if_id_valid = 1'b1;
        if_id_bus = '{pc: pc_next, inst: inst};
        forever begin
            @(negedge clk);
            if (id_allowin) begin
                @(posedge clk);
                #1;
                break;
            end
            n++;
            if (n > LIMIT) begin
                timeouts++;
                $display("timeout: the stage never accepted instruction %h", inst);
                break;
            end
        end
        if (n <= LIMIT && expect_leave) pending.push_back(if_id_bus);
        if_id_valid = 1'b0;
        pc_next += 32'd4;
    endtask

    task automatic drain();
        int n;
        n = 0;
        while (pending.size() != 0 && n <= LIMIT) begin
            @(posedge clk);
            n++;
        end
        if (n > LIMIT) begin
            timeouts++;
            $display("timeout: %0d instructions never reached execute", pending.size());
            pending.delete();
        end
        @(posedge clk);
        #1;
    endtask

    function automatic word_t rand_inst();
        logic [4:0] fns [11] = '{FN_ADD, FN_SUB, FN_SLT, FN_SLTU, FN_NOR, FN_AND,
                                 FN_OR, FN_XOR, FN_SLL, FN_SRL, FN_SRA};
        logic [4:0] shf [3] = '{FN_SLLI, FN_SRLI, FN_SRAI};
        logic [3:0] imo [6] = '{OP2_SLTI, OP2_SLTUI, OP2_ADDI, OP2_ANDI, OP2_ORI, OP2_XORI};
        logic [3:0] lso [8] = '{LS_LD_B, LS_LD_H, LS_LD_W, LS_LD_BU, LS_LD_HU,
                                LS_ST_B, LS_ST_H, LS_ST_W};
        word_t r;
        word_t f;
        r = lcg_next();
        f = lcg_next();
        case (r[2:0])
            3'd0, 3'd1: return {OP_ALU, OP2_3R, OP3_3R, fns[r[9:4] % 11], f[14:0]};
            3'd2: return {OP_ALU, OP2_SHI, OP3_SHI, shf[r[9:4] % 3], f[14:0]};
            3'd3: return {OP_ALU, imo[r[9:4] % 6], f[21:0]};
            3'd4: return {r[8] ? OP_LU12I : OP_PCADDU12I, 1'b0, f[24:0]};
            default: return {OP_LDST, lso[r[9:4] % 8], f[21:0]};
        endcase
    endfunction

    initial begin
        word_t v;
        word_t binst;
        id_ex_t ref_ex;
        br_t ref_br;
        shadow[0] = 32'd0;
        repeat (5) @(posedge clk);
        #1;
        resetn = 1'b1;
        for (int i = 1; i < 32; i++) begin
            set_wb(1'b1, 5'(i), lcg_next());
            @(posedge clk);
            #1;
        end
        set_wb(1'b0, 5'd0, 32'd0);
        // random decode with forwarding idle
        repeat (60) offer(rand_inst(), 1'b1);
        drain();
        // forwarding priority on r7
        ex_fwd = '{valid: 1'b1, is_load: 1'b0, dest: 5'd7, wdata: 32'h1111_0000};
        mem_fwd = '{valid: 1'b1, is_load: 1'b0, dest: 5'd7, wdata: 32'h2222_0000};
        set_wb(1'b1, 5'd7, 32'h3333_0000);
        offer({10'h000, 2'h1, FN_ADD, 5'd7, 5'd7, 5'd3}, 1'b1);
        drain();
        ex_fwd = '0;
        offer({10'h000, 2'h1, FN_ADD, 5'd7, 5'd7, 5'd3}, 1'b1);
        drain();
        mem_fwd = '0;
        offer({10'h000, 2'h1, FN_ADD, 5'd7, 5'd7, 5'd3}, 1'b1);
        set_wb(1'b1, 5'd7, 32'h7777_0000); // regfile still holds the older value
        drain();
        ex_fwd = '{valid: 1'b1, is_load: 1'b0, dest: 5'd0, wdata: 32'h4444_0000};
        mem_fwd = '{valid: 1'b1, is_load: 1'b0, dest: 5'd0, wdata: 32'h5555_0000};
        set_wb(1'b1, 5'd0, 32'h6666_0000);
        offer({10'h000, 2'h1, FN_OR, 5'd0, 5'd0, 5'd3}, 1'b1);
        drain();
        ex_fwd = '0;
        mem_fwd = '0;
        set_wb(1'b0, 5'd0, 32'd0);
        // load-use on r8
        ex_fwd = '{valid: 1'b1, is_load: 1'b1, dest: 5'd8, wdata: 32'hdead_0008};
        offer({10'h000, 2'h1, FN_SUB, 5'd8, 5'd9, 5'd10}, 1'b1);
        repeat (4) begin
            @(negedge clk);
            assert (!id_ex_valid) else begin
                errors++;
                $display("CHECK FAILED at %0t: issued during load-use stall", $time);
            end
        end
        @(posedge clk);
        #1;
        ex_fwd.is_load = 1'b0;
        drain();
        ex_fwd = '0;
        // conditional branches, then b, bl and jirl, each followed by a victim
        for (int k = 0; k < 6; k++) begin
            v = lcg_next();
            binst = {OP_BEQ + 6'(k), v[15:0], v[20:16] | 5'd1,
                     v[24] ? v[20:16] | 5'd1 : v[29:25]};
            id_ref_decode(binst, pc_next, ref_ex, ref_br);
            offer(binst, 1'b1);
            offer({10'h000, 2'h1, FN_ADD, 5'd2, 5'd3, 5'd4}, !ref_br.taken);
            drain();
        end
        set_wb(1'b1, 5'd4, lcg_next() & ~32'h3);
        @(posedge clk);
        #1;
        set_wb(1'b0, 5'd0, 32'd0);
        v = lcg_next();
        offer({OP_B, v[25:0]}, 1'b1);
        offer({10'h000, 2'h1, FN_XOR, 5'd2, 5'd3, 5'd4}, 1'b0);
        offer({OP_BL, v[31:6]}, 1'b1);
        offer({10'h000, 2'h1, FN_XOR, 5'd2, 5'd3, 5'd4}, 1'b0);
        offer({OP_JIRL, v[17:2], 5'd4, 5'd5}, 1'b1);
        offer({10'h000, 2'h1, FN_XOR, 5'd2, 5'd3, 5'd4}, 1'b0);
        drain();
        // back-pressure holds one copy
        ex_allowin = 1'b0;
        offer({OP_ALU, OP2_ADDI, 12'h7f0, 5'd11, 5'd12}, 1'b1);
        repeat (3) begin
            @(negedge clk);
            assert (!id_allowin && id_ex_valid) else begin
                errors++;
                $display("CHECK FAILED at %0t: instruction not held under back-pressure", $time);
            end
        end
        @(posedge clk);
        #1;
        ex_allowin = 1'b1;
        drain();
        // flush drops the held instruction
        ex_allowin = 1'b0;
        offer({OP_ALU, OP2_ORI, 12'h0f0, 5'd13, 5'd14}, 1'b0);
        flush = 1'b1;
        @(posedge clk);
        #1;
        flush = 1'b0;
        ex_allowin = 1'b1;
        repeat (4) @(posedge clk);
        #1;
        // unrecognised word
        offer(32'hfc00_1234, 1'b1);
        drain();
        $display("errors=%0d timeouts=%0d", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

/* hdl/branch_unit.sv */
module branch_unit (
    input  id_pkg::dec_t  dec,
    input  id_pkg::word_t pc,
    input  id_pkg::word_t rj_value,
    input  id_pkg::word_t rkd_value,
    output id_pkg::br_t   br
);
    import id_pkg::*;

    logic eq;
    logic lt_s;
    logic lt_u;
    logic cond;

    assign eq   = rj_value == rkd_value;
    assign lt_s = $signed(rj_value) < $signed(rkd_value);
    assign lt_u = rj_value < rkd_value;

    always_comb begin
        case (dec.br_kind)
            BR_EQ:   cond = eq;
            BR_NE:   cond = !eq;
            BR_LT:   cond = lt_s;
            BR_GE:   cond = !lt_s;
            BR_LTU:  cond = lt_u;
            BR_GEU:  cond = !lt_u;
            default: cond = 1'b0;
        endcase
    end

    assign br.taken  = dec.is_jump_pc || dec.is_jirl || (dec.is_branch_cond && cond);
    assign br.target = (dec.is_jirl ? rj_value : pc) + dec.br_offs; // jirl is register relative

endmodule

/* hdl/id_pkg.sv */
package id_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_idx_t;
    typedef logic [11:0] alu_op_t;
    typedef logic [2:0]  mem_size_t;

    // one-hot bit positions of alu_op_t
    localparam int ALU_ADD  = 0;
    localparam int ALU_SUB  = 1;
    localparam int ALU_SLT  = 2;
    localparam int ALU_SLTU = 3;
    localparam int ALU_AND  = 4;
    localparam int ALU_NOR  = 5;
    localparam int ALU_OR   = 6;
    localparam int ALU_XOR  = 7;
    localparam int ALU_SLL  = 8;
    localparam int ALU_SRL  = 9;
    localparam int ALU_SRA  = 10;
    localparam int ALU_LUI  = 11;

    localparam mem_size_t MEM_W  = 3'b000;
    localparam mem_size_t MEM_H  = 3'b001;
    localparam mem_size_t MEM_B  = 3'b010;
    localparam mem_size_t MEM_HU = 3'b101; // bit 2 marks zero extension
    localparam mem_size_t MEM_BU = 3'b110;

    // primary opcode, inst[31:26]
    localparam logic [5:0] OP_ALU       = 6'h00;
    localparam logic [5:0] OP_LU12I     = 6'h05;
    localparam logic [5:0] OP_PCADDU12I = 6'h07;
    localparam logic [5:0] OP_LDST      = 6'h0a;
    localparam logic [5:0] OP_JIRL      = 6'h13;
    localparam logic [5:0] OP_B         = 6'h14;
    localparam logic [5:0] OP_BL        = 6'h15;
    localparam logic [5:0] OP_BEQ       = 6'h16;
    localparam logic [5:0] OP_BNE       = 6'h17;
    localparam logic [5:0] OP_BLT       = 6'h18;
    localparam logic [5:0] OP_BGE       = 6'h19;
    localparam logic [5:0] OP_BLTU      = 6'h1a;
    localparam logic [5:0] OP_BGEU      = 6'h1b;

    // inst[25:22] under OP_ALU
    localparam logic [3:0] OP2_3R    = 4'h0;
    localparam logic [3:0] OP2_SHI   = 4'h1;
    localparam logic [3:0] OP2_SLTI  = 4'h8;
    localparam logic [3:0] OP2_SLTUI = 4'h9;
    localparam logic [3:0] OP2_ADDI  = 4'ha;
    localparam logic [3:0] OP2_ANDI  = 4'hd;
    localparam logic [3:0] OP2_ORI   = 4'he;
    localparam logic [3:0] OP2_XORI  = 4'hf;

    // inst[25:22] under OP_LDST
    localparam logic [3:0] LS_LD_B  = 4'h0;
    localparam logic [3:0] LS_LD_H  = 4'h1;
    localparam logic [3:0] LS_LD_W  = 4'h2;
    localparam logic [3:0] LS_ST_B  = 4'h4;
    localparam logic [3:0] LS_ST_H  = 4'h5;
    localparam logic [3:0] LS_ST_W  = 4'h6;
    localparam logic [3:0] LS_LD_BU = 4'h8;
    localparam logic [3:0] LS_LD_HU = 4'h9;

    // inst[21:20]
    localparam logic [1:0] OP3_SHI = 2'h0;
    localparam logic [1:0] OP3_3R  = 2'h1;

    // inst[19:15]
    localparam logic [4:0] FN_ADD  = 5'h00;
    localparam logic [4:0] FN_SUB  = 5'h02;
    localparam logic [4:0] FN_SLT  = 5'h04;
    localparam logic [4:0] FN_SLTU = 5'h05;
    localparam logic [4:0] FN_NOR  = 5'h08;
    localparam logic [4:0] FN_AND  = 5'h09;
    localparam logic [4:0] FN_OR   = 5'h0a;
    localparam logic [4:0] FN_XOR  = 5'h0b;
    localparam logic [4:0] FN_SLL  = 5'h0e;
    localparam logic [4:0] FN_SRL  = 5'h0f;
    localparam logic [4:0] FN_SRA  = 5'h10;
    localparam logic [4:0] FN_SLLI = 5'h01;
    localparam logic [4:0] FN_SRLI = 5'h09;
    localparam logic [4:0] FN_SRAI = 5'h11;

    // br_kind, same order as OP_BEQ..OP_BGEU
    localparam logic [2:0] BR_EQ  = 3'd0;
    localparam logic [2:0] BR_NE  = 3'd1;
    localparam logic [2:0] BR_LT  = 3'd2;
    localparam logic [2:0] BR_GE  = 3'd3;
    localparam logic [2:0] BR_LTU = 3'd4;
    localparam logic [2:0] BR_GEU = 3'd5;

    localparam reg_idx_t RA_LINK = 5'd1;

    typedef struct packed {
        word_t pc;
        word_t inst;
    } if_id_t;

    typedef struct packed {
        logic     valid;
        logic     is_load;
        reg_idx_t dest;
        word_t    wdata;
    } fwd_t;

    typedef struct packed {
        logic     we;
        reg_idx_t waddr;
        word_t    wdata;
    } wb_t;

    typedef struct packed {
        logic  taken;
        word_t target;
    } br_t;

    typedef struct packed {
        alu_op_t    alu_op;
        logic       src1_is_pc;
        logic       src2_is_imm;
        logic       gr_we;
        reg_idx_t   dest;
        logic       is_load;
        logic       is_store;
        mem_size_t  mem_size;
        logic       is_branch_cond;
        logic [2:0] br_kind;
        logic       is_jump_pc;
        logic       is_jirl;
        logic       need_rj;
        logic       need_rkd;
        logic       rkd_is_rd;
        logic       ine;
        word_t      imm;
        word_t      br_offs;
    } dec_t;

    typedef struct packed {
        word_t     pc;
        alu_op_t   alu_op;
        word_t     alu_src1;
        word_t     alu_src2;
        word_t     rkd_value;
        reg_idx_t  dest;
        logic      gr_we;
        logic      is_load;
        logic      is_store;
        mem_size_t mem_size;
        logic      ine;
    } id_ex_t;

endpackage

/* hdl/id_stage.sv */
module id_stage (
    input  logic             clk,
    input  logic             resetn,
    input  logic             if_id_valid,
    input  id_pkg::if_id_t   if_id_bus,
    output logic             id_allowin,
    input  logic             ex_allowin,
    output logic             id_ex_valid,
    output id_pkg::id_ex_t   id_ex_bus,
    input  id_pkg::fwd_t     ex_fwd,
    input  id_pkg::fwd_t     mem_fwd,
    input  id_pkg::wb_t      wb_bus,
    input  logic             flush,
    output id_pkg::br_t      id_br
);
    import id_pkg::*;

    logic     id_valid;
    if_id_t   id_bus_r;
    dec_t     dec;
    reg_idx_t rj;
    reg_idx_t rkd_idx;
    word_t    rf_rdata1;
    word_t    rf_rdata2;
    word_t    rj_value;
    word_t    rkd_value;
    logic     load_use;
    br_t      br_raw;

    assign id_ex_valid = id_valid && !load_use && !flush;
    assign id_allowin  = !id_valid || (id_ex_valid && ex_allowin) || flush;

    // taken only when the branch itself issues, so it is never lost to back-pressure
    assign id_br.taken  = br_raw.taken && id_ex_valid && ex_allowin;
    assign id_br.target = br_raw.target;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            id_valid <= 1'b0;
        end else if (flush || id_br.taken) begin
            id_valid <= 1'b0; // drops the fetch offer of this cycle too
        end else if (id_allowin) begin
            id_valid <= if_id_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (if_id_valid && id_allowin) begin
            id_bus_r <= if_id_bus;
        end
    end

    inst_decoder u_dec (
        .inst    (id_bus_r.inst),
        .dec     (dec),
        .rj      (rj),
        .rkd_idx (rkd_idx)
    );

    regfile u_rf (
        .clk    (clk),
        .raddr1 (rj),
        .rdata1 (rf_rdata1),
        .raddr2 (rkd_idx),
        .rdata2 (rf_rdata2),
        .we     (wb_bus.we),
        .waddr  (wb_bus.waddr),
        .wdata  (wb_bus.wdata)
    );

    operand_bypass u_byp (
        .rj        (rj),
        .rkd_idx   (rkd_idx),
        .need_rj   (dec.need_rj),
        .need_rkd  (dec.need_rkd),
        .rf_rdata1 (rf_rdata1),
        .rf_rdata2 (rf_rdata2),
        .ex_fwd    (ex_fwd),
        .mem_fwd   (mem_fwd),
        .wb_bus    (wb_bus),
        .rj_value  (rj_value),
        .rkd_value (rkd_value),
        .load_use  (load_use)
    );

    branch_unit u_br (
        .dec       (dec),
        .pc        (id_bus_r.pc),
        .rj_value  (rj_value),
        .rkd_value (rkd_value),
        .br        (br_raw)
    );

    always_comb begin
        id_ex_bus.pc        = id_bus_r.pc;
        id_ex_bus.alu_op    = dec.alu_op;
        id_ex_bus.alu_src1  = dec.src1_is_pc ? id_bus_r.pc : rj_value;
        id_ex_bus.alu_src2  = dec.src2_is_imm ? dec.imm : rkd_value;
        id_ex_bus.rkd_value = rkd_value; // store data
        id_ex_bus.dest      = dec.dest;
        id_ex_bus.gr_we     = dec.gr_we;
        id_ex_bus.is_load   = dec.is_load;
        id_ex_bus.is_store  = dec.is_store;
        id_ex_bus.mem_size  = dec.mem_size;
        id_ex_bus.ine       = dec.ine;
    end

    a_target_aligned: assert property (@(posedge clk) disable iff (!resetn)
        id_br.taken |-> id_br.target[1:0] == 2'b00)
        else $error("taken branch target not word aligned");

    // execute may sample the bus in any cycle of a stall
    a_bus_stable: assert property (@(posedge clk) disable iff (!resetn)
        id_ex_valid && !ex_allowin |=> $stable(id_ex_bus))
        else $error("id_ex_bus changed under back-pressure");

endmodule

/* hdl/inst_decoder.sv */
module inst_decoder (
    input  id_pkg::word_t    inst,
    output id_pkg::dec_t     dec,
    output id_pkg::reg_idx_t rj,
    output id_pkg::reg_idx_t rkd_idx
);
    import id_pkg::*;

    logic [5:0]  op;
    logic [3:0]  op2;
    logic [1:0]  op3;
    logic [4:0]  fn;
    reg_idx_t    rd;
    reg_idx_t    rk;
    logic [11:0] i12;
    logic [19:0] i20;
    logic [15:0] i16;
    logic [25:0] i26;

    assign op  = inst[31:26];
    assign op2 = inst[25:22];
    assign op3 = inst[21:20];
    assign fn  = inst[19:15];
    assign rd  = inst[4:0];
    assign rj  = inst[9:5];
    assign rk  = inst[14:10];
    assign i12 = inst[21:10];
    assign i20 = inst[24:5];
    assign i16 = inst[25:10];
    assign i26 = {inst[9:0], inst[25:10]};

    assign rkd_idx = dec.rkd_is_rd ? rd : rk;

    always_comb begin
        dec          = '0;
        dec.dest     = rd;
        dec.gr_we    = 1'b1;
        dec.mem_size = MEM_W;
        dec.br_offs  = {{14{i16[15]}}, i16, 2'b00};
        dec.ine      = 1'b1; // cleared on a match
        case (op)
            OP_ALU: begin
                dec.ine     = 1'b0;
                dec.need_rj = 1'b1;
                if (op2 == OP2_3R && op3 == OP3_3R) begin
                    dec.need_rkd = 1'b1;
                    case (fn)
                        FN_ADD:  dec.alu_op[ALU_ADD]  = 1'b1;
                        FN_SUB:  dec.alu_op[ALU_SUB]  = 1'b1;
                        FN_SLT:  dec.alu_op[ALU_SLT]  = 1'b1;
                        FN_SLTU: dec.alu_op[ALU_SLTU] = 1'b1;
                        FN_NOR:  dec.alu_op[ALU_NOR]  = 1'b1;
                        FN_AND:  dec.alu_op[ALU_AND]  = 1'b1;
                        FN_OR:   dec.alu_op[ALU_OR]   = 1'b1;
                        FN_XOR:  dec.alu_op[ALU_XOR]  = 1'b1;
                        FN_SLL:  dec.alu_op[ALU_SLL]  = 1'b1;
                        FN_SRL:  dec.alu_op[ALU_SRL]  = 1'b1;
                        FN_SRA:  dec.alu_op[ALU_SRA]  = 1'b1;
                        default: dec.ine = 1'b1;
                    endcase
                end else if (op2 == OP2_SHI && op3 == OP3_SHI) begin
                    dec.src2_is_imm = 1'b1;
                    dec.imm         = {27'b0, rk}; // ui5
                    case (fn)
                        FN_SLLI: dec.alu_op[ALU_SLL] = 1'b1;
                        FN_SRLI: dec.alu_op[ALU_SRL] = 1'b1;
                        FN_SRAI: dec.alu_op[ALU_SRA] = 1'b1;
                        default: dec.ine = 1'b1;
                    endcase
                end else begin
                    dec.src2_is_imm = 1'b1;
                    dec.imm         = {{20{i12[11]}}, i12};
                    case (op2)
                        OP2_SLTI:  dec.alu_op[ALU_SLT]  = 1'b1;
                        OP2_SLTUI: dec.alu_op[ALU_SLTU] = 1'b1;
                        OP2_ADDI:  dec.alu_op[ALU_ADD]  = 1'b1;
                        OP2_ANDI, OP2_ORI, OP2_XORI: begin
                            dec.imm = {20'b0, i12}; // logic ops zero extend
                            dec.alu_op[ALU_AND] = (op2 == OP2_ANDI);
                            dec.alu_op[ALU_OR]  = (op2 == OP2_ORI);
                            dec.alu_op[ALU_XOR] = (op2 == OP2_XORI);
                        end
                        default: dec.ine = 1'b1;
                    endcase
                end
            end
            OP_LDST: begin
                dec.ine             = 1'b0;
                dec.need_rj         = 1'b1;
                dec.src2_is_imm     = 1'b1;
                dec.imm             = {{20{i12[11]}}, i12};
                dec.alu_op[ALU_ADD] = 1'b1; // address = rj + si12
                case (op2)
                    LS_LD_B, LS_LD_H, LS_LD_W, LS_LD_BU, LS_LD_HU: begin
                        dec.is_load = 1'b1;
                        case (op2)
                            LS_LD_B:  dec.mem_size = MEM_B;
                            LS_LD_H:  dec.mem_size = MEM_H;
                            LS_LD_BU: dec.mem_size = MEM_BU;
                            LS_LD_HU: dec.mem_size = MEM_HU;
                            default:  dec.mem_size = MEM_W;
                        endcase
                    end
                    LS_ST_B, LS_ST_H, LS_ST_W: begin
                        dec.is_store  = 1'b1;
                        dec.gr_we     = 1'b0;
                        dec.need_rkd  = 1'b1;
                        dec.rkd_is_rd = 1'b1; // store data comes from rd
                        dec.mem_size  = (op2 == LS_ST_B) ? MEM_B :
                                        (op2 == LS_ST_H) ? MEM_H : MEM_W;
                    end
                    default: dec.ine = 1'b1;
                endcase
            end
            OP_LU12I, OP_PCADDU12I: begin
                if (!inst[25]) begin
                    dec.ine         = 1'b0;
                    dec.src2_is_imm = 1'b1;
                    dec.imm         = {i20, 12'b0};
                    dec.src1_is_pc  = (op == OP_PCADDU12I);
                    dec.alu_op[ALU_LUI] = (op == OP_LU12I);
                    dec.alu_op[ALU_ADD] = (op == OP_PCADDU12I);
                end
            end
            OP_JIRL: begin
                dec.ine             = 1'b0;
                dec.is_jirl         = 1'b1;
                dec.need_rj         = 1'b1;
                dec.src1_is_pc      = 1'b1;
                dec.src2_is_imm     = 1'b1;
                dec.imm             = 32'd4; // link value pc + 4
                dec.alu_op[ALU_ADD] = 1'b1;
            end
            OP_B, OP_BL: begin
                dec.ine        = 1'b0;
                dec.is_jump_pc = 1'b1;
                dec.br_offs    = {{4{i26[25]}}, i26, 2'b00};
                if (op == OP_BL) begin
                    dec.dest            = RA_LINK;
                    dec.src1_is_pc      = 1'b1;
                    dec.src2_is_imm     = 1'b1;
                    dec.imm             = 32'd4;
                    dec.alu_op[ALU_ADD] = 1'b1;
                end else begin
                    dec.gr_we = 1'b0;
                end
            end
            OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU: begin
                dec.ine            = 1'b0;
                dec.is_branch_cond = 1'b1;
                dec.br_kind        = 3'(op - OP_BEQ);
                dec.gr_we          = 1'b0;
                dec.need_rj        = 1'b1;
                dec.need_rkd       = 1'b1;
                dec.rkd_is_rd      = 1'b1;
            end
            default: ;
        endcase
        if (dec.ine) begin
            dec.alu_op   = '0;
            dec.gr_we    = 1'b0;
            dec.need_rj  = 1'b0;
            dec.need_rkd = 1'b0;
        end
    end

endmodule

/* hdl/operand_bypass.sv */
module operand_bypass (
    input  id_pkg::reg_idx_t rj,
    input  id_pkg::reg_idx_t rkd_idx,
    input  logic             need_rj,
    input  logic             need_rkd,
    input  id_pkg::word_t    rf_rdata1,
    input  id_pkg::word_t    rf_rdata2,
    input  id_pkg::fwd_t     ex_fwd,
    input  id_pkg::fwd_t     mem_fwd,
    input  id_pkg::wb_t      wb_bus,
    output id_pkg::word_t    rj_value,
    output id_pkg::word_t    rkd_value,
    output logic             load_use
);
    import id_pkg::*;

    logic rj_live;
    logic rkd_live;

    // youngest producer wins
    function automatic word_t pick(input reg_idx_t idx, input logic live, input word_t rf_val);
        if (!live) begin
            return rf_val;
        end
        if (ex_fwd.valid && ex_fwd.dest == idx) begin
            return ex_fwd.wdata;
        end
        if (mem_fwd.valid && mem_fwd.dest == idx) begin
            return mem_fwd.wdata;
        end
        if (wb_bus.we && wb_bus.waddr == idx) begin
            return wb_bus.wdata; // not yet in the regfile this cycle
        end
        return rf_val;
    endfunction

    assign rj_live  = need_rj && rj != '0;
    assign rkd_live = need_rkd && rkd_idx != '0;

    assign rj_value  = pick(rj, rj_live, rf_rdata1);
    assign rkd_value = pick(rkd_idx, rkd_live, rf_rdata2);

    assign load_use = ex_fwd.valid && ex_fwd.is_load &&
                      ((rj_live && ex_fwd.dest == rj) || (rkd_live && ex_fwd.dest == rkd_idx));

    // r0 must come out of the regfile as zero, never from a later stage
    always_comb begin
        if (need_rj && rj == '0) begin
            assert final (rj_value == '0)
                else $error("nonzero operand on rj index 0");
        end
        if (need_rkd && rkd_idx == '0) begin
            assert final (rkd_value == '0)
                else $error("nonzero operand on rkd index 0");
        end
    end

endmodule

/* hdl/regfile.sv */
module regfile (
    input  logic             clk,
    input  id_pkg::reg_idx_t raddr1,
    output id_pkg::word_t    rdata1,
    input  id_pkg::reg_idx_t raddr2,
    output id_pkg::word_t    rdata2,
    input  logic             we,
    input  id_pkg::reg_idx_t waddr,
    input  id_pkg::word_t    wdata
);
    import id_pkg::*;

    word_t rf [1:31]; // r0 has no storage

    always_ff @(posedge clk) begin
        if (we && waddr != '0) begin
            rf[waddr] <= wdata;
        end
    end

    assign rdata1 = (raddr1 == '0) ? '0 : rf[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : rf[raddr2];

endmodule
